/* flist.f */
+incdir+.
sprite_pkg.sv
sprite_line_sequencer.sv
sprite_pixel_drawer.sv
sprite_line_buffer.sv
sprite_engine.sv
sprite_engine_sva.sv
tb_sprite_engine.sv

/* Makefile */
TOOL       := verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall
TOP        := tb_sprite_engine
FLIST      := flist.f
BUILD      := obj_dir
LOG        := sim.log
SIM_ARGS   := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation failed"; exit 1; fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)

/* tb_sprite_engine.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sprite_consts.svh"

module tb_sprite_engine;

	localparam int LINE_CYCLES = 4000;
	localparam int NUM_LINES = 10;

	logic clk;
	logic rst_n;
	logic hsync;
	logic [8:0] vcnt;
	logic [8:0] hcnt;
	sprite_pkg::sram_addr_t spriteram_addr;
	logic [7:0] spriteram_data;
	sprite_pkg::rom_addr_t sprom_addr;
	logic [7:0] sprom_data;
	sprite_pkg::pal_addr_t palrom_addr;
	sprite_pkg::color_t palrom_data;
	sprite_pkg::rgb_t pixel;

	logic [7:0] sram [0:127];
	logic [7:0] image_rom [0:16383];
	sprite_pkg::color_t pal_rom [0:255];

	// Expected line being drawn now, and the one being read out
	sprite_pkg::color_t exp_cur [0:511];
	sprite_pkg::color_t exp_show [0:511];
	string cur_name;
	string show_name;
	logic cur_valid;
	logic show_valid;

	logic [15:0] lfsr;
	int cyc = 0;
	int checks;
	int pixel_errors;
	int sva_errors;
	sprite_pkg::sram_addr_t sram_addr_q;
	sprite_pkg::rom_addr_t rom_addr_q;
	sprite_pkg::pal_addr_t pal_addr_q;

	sprite_engine u_sprite_engine (
		.clk            (clk),
		.rst_n          (rst_n),
		.hsync          (hsync),
		.vcnt           (vcnt),
		.hcnt           (hcnt),
		.spriteram_addr (spriteram_addr),
		.spriteram_data (spriteram_data),
		.sprom_addr     (sprom_addr),
		.sprom_data     (sprom_data),
		.palrom_addr    (palrom_addr),
		.palrom_data    (palrom_data),
		.pixel          (pixel)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	// The three memories take the address at the edge and answer 1 ns later
	always @(posedge clk)
	begin
		sram_addr_q = spriteram_addr;
		rom_addr_q = sprom_addr;
		pal_addr_q = palrom_addr;
		#1;
		spriteram_data = sram[sram_addr_q];
		sprom_data = image_rom[rom_addr_q];
		palrom_data = pal_rom[pal_addr_q];
	end

	// Fibonacci LFSR stepped once per bit taken
	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] val;
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			val = {val[14:0], fb};
		end
		return val;
	endfunction

	function automatic sprite_pkg::rgb_t expand(input sprite_pkg::color_t c);
		sprite_pkg::rgb_t p;
		p.r = {c[4:0], c[4:2]};
		p.g = {c[9:5], c[9:7]};
		p.b = {c[14:10], c[14:12]};
		p.a = c[15];
		return p;
	endfunction

	task automatic set_sprite(input int n, input logic en, input logic [1:0] pal,
		input logic [5:0] img, input logic [9:0] x, input logic [9:0] y);
		sram[7'(n * `SPR_ATTR_STRIDE)] = {en, 1'b0, pal, 2'b00, y[9:8]};
		sram[7'(n * `SPR_ATTR_STRIDE + 1)] = y[7:0];
		sram[7'(n * `SPR_ATTR_STRIDE + 2)] = {img, x[9:8]};
		sram[7'(n * `SPR_ATTR_STRIDE + 3)] = x[7:0];
	endtask

	// Line model built from the attribute layout, ROM address and palette rules
	task automatic build_expected(input int v);
		int active;
		int y;
		int row;
		logic [7:0] b0;
		logic [7:0] b2;
		logic [9:0] xs;
		logic [7:0] d;
		sprite_pkg::color_t c;
		for (int x = 0; x < 512; x++)
			exp_cur[9'(x)] = '0;
		active = v + `SPR_SIZE;
		for (int n = 0; n < `SPR_COUNT; n++)
		begin
			b0 = sram[7'(n * `SPR_ATTR_STRIDE)];
			b2 = sram[7'(n * `SPR_ATTR_STRIDE + 2)];
			y = int'({b0[1:0], sram[7'(n * `SPR_ATTR_STRIDE + 1)]});
			xs = {b2[1:0], sram[7'(n * `SPR_ATTR_STRIDE + 3)]};
			if (b0[7] && active >= y && active <= y + `SPR_SIZE - 1)
			begin
				row = active - y;
				for (int p = 0; p < `SPR_SIZE; p++)
				begin
					d = image_rom[14'(int'(b2[7:2]) * 256 + row * 16 + p)];
					c = pal_rom[{b0[5:4], d[4:0], 1'b0}];
					if (c[15])
						exp_cur[9'(int'(xs[8:0]) + p)] = c;
				end
			end
		end
	endtask

	task automatic sweep_line();
		sprite_pkg::rgb_t want;
		for (int x = 0; x <= `LINE_LAST; x++)
		begin
			@(posedge clk);
			#1;
			hcnt = 9'(x - `READ_OFFSET);
			@(posedge clk);
			@(negedge clk);
			want = expand(exp_show[9'(x)]);
			checks++;
			assert (pixel === want)
			else
			begin
				pixel_errors++;
				$display("error %s x=%0d expected %h actual %h",
					show_name, x, want, pixel);
			end
		end
	endtask

	// One hsync period starts a new line and reads back the one drawn before
	task automatic run_line(input string name, input int v);
		int start;
		start = cyc;
		@(posedge clk);
		#1;
		vcnt = 9'(v);
		hsync = 1'b1;
		@(posedge clk);
		#1;
		hsync = 1'b0;
		exp_show = exp_cur;
		show_name = cur_name;
		show_valid = cur_valid;
		build_expected(v);
		cur_name = name;
		cur_valid = 1'b1;
		// Swap lands two cycles after the rise and the read slot flips one later
		repeat (4) @(posedge clk);
		if (show_valid)
			sweep_line();
		while (cyc - start < LINE_CYCLES)
			@(posedge clk);
	endtask

	initial
	begin
		rst_n = 1'b0;
		hsync = 1'b0;
		vcnt = '0;
		hcnt = '0;
		spriteram_data = '0;
		sprom_data = '0;
		palrom_data = '0;
		lfsr = 16'd89;
		checks = 0;
		pixel_errors = 0;
		cur_valid = 1'b0;
		show_valid = 1'b0;
		cur_name = "reset";
		for (int i = 0; i < 16384; i++)
			image_rom[14'(i)] = 8'(take_bits(8));
		for (int i = 0; i < 256; i++)
		begin
			pal_rom[8'(i)] = take_bits(16);
			// Colour indices ending in 0 are transparent
			pal_rom[8'(i)][15] = i[1];
		end
		for (int i = 0; i < 128; i++)
			sram[7'(i)] = '0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		run_line("all_disabled", 0);
		set_sprite(3, 1'b1, 2'd1, 6'd5, 10'd100, 10'd40);
		run_line("above_band", 23);
		run_line("band_top", 24);
		run_line("band_mid", 32);
		run_line("band_bottom", 39);
		run_line("below_band", 40);
		set_sprite(7, 1'b1, 2'd2, 6'd9, 10'd108, 10'd40);
		run_line("overlap", 30);
		set_sprite(3, 1'b1, 2'd3, 6'd12, 10'd100, 10'd41);
		run_line("new_pal_img_y", 30);
		set_sprite(3, 1'b0, 2'd3, 6'd12, 10'd100, 10'd41);
		set_sprite(7, 1'b0, 2'd2, 6'd9, 10'd108, 10'd40);
		run_line("stale_cleared", 30);
		run_line("flush", 30);

		sva_errors = u_sprite_engine.u_sva.fail_count;
		$display("checks %0d, pixel errors %0d, assertion errors %0d",
			checks, pixel_errors, sva_errors);
		if (pixel_errors == 0 && sva_errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin
		#(NUM_LINES * LINE_CYCLES * 8 + 2000 * 8);
		$display("timeout: the lines did not finish in the expected time");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* sprite_engine_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module sprite_engine_sva (
	input logic                     clk,
	input logic                     rst_n,
	input logic                     swap,
	input logic                     clear_busy,
	input sprite_pkg::lb_write_t    lb_wr,
	input logic                     draw_start,
	input logic                     draw_done,
	input sprite_pkg::sprite_desc_t desc
);

	int fail_count = 0;
	logic drawing;

	// High from the cycle after draw_start through the draw_done cycle
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			drawing <= 1'b0;
		else if (draw_start)
			drawing <= 1'b1;
		else if (draw_done)
			drawing <= 1'b0;
	end

	swap_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) swap |=> !swap)
	else
	begin
		$error("swap held for more than one cycle");
		fail_count++;
	end

	no_write_in_clear: assert property (@(posedge clk) disable iff (!rst_n)
		clear_busy |-> !lb_wr.we)
	else
	begin
		$error("line buffer write while clear_busy is high");
		fail_count++;
	end

	start_after_done: assert property (@(posedge clk) disable iff (!rst_n)
		draw_start |-> !drawing)
	else
	begin
		$error("draw_start repeated before draw_done");
		fail_count++;
	end

	desc_stable: assert property (@(posedge clk) disable iff (!rst_n)
		drawing |-> $stable(desc))
	else
	begin
		$error("desc changed during a draw");
		fail_count++;
	end

endmodule

bind sprite_engine sprite_engine_sva u_sva (
	.clk        (clk),
	.rst_n      (rst_n),
	.swap       (swap),
	.clear_busy (clear_busy),
	.lb_wr      (lb_wr),
	.draw_start (draw_start),
	.draw_done  (draw_done),
	.desc       (desc)
);

`default_nettype wire

/* sprite_engine.sv */
`timescale 1ns/100ps
`default_nettype none

module sprite_engine (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   hsync,
	input  logic [8:0]             vcnt,
	input  logic [8:0]             hcnt,
	output sprite_pkg::sram_addr_t spriteram_addr,
	input  logic [7:0]             spriteram_data,
	output sprite_pkg::rom_addr_t  sprom_addr,
	input  logic [7:0]             sprom_data,
	output sprite_pkg::pal_addr_t  palrom_addr,
	input  sprite_pkg::color_t     palrom_data,
	output sprite_pkg::rgb_t       pixel
);

	logic swap;
	logic clear_busy;
	logic draw_start;
	logic draw_done;
	sprite_pkg::sprite_desc_t desc;
	sprite_pkg::lb_write_t lb_wr;

	sprite_line_sequencer u_sequencer (
		.clk            (clk),
		.rst_n          (rst_n),
		.hsync          (hsync),
		.vcnt           (vcnt),
		.clear_busy     (clear_busy),
		.draw_done      (draw_done),
		.swap           (swap),
		.spriteram_addr (spriteram_addr),
		.spriteram_data (spriteram_data),
		.desc           (desc),
		.draw_start     (draw_start)
	);

	sprite_pixel_drawer u_drawer (
		.clk         (clk),
		.rst_n       (rst_n),
		.desc        (desc),
		.draw_start  (draw_start),
		.draw_done   (draw_done),
		.sprom_addr  (sprom_addr),
		.sprom_data  (sprom_data),
		.palrom_addr (palrom_addr),
		.palrom_data (palrom_data),
		.lb_wr       (lb_wr)
	);

	sprite_line_buffer u_line_buffer (
		.clk        (clk),
		.rst_n      (rst_n),
		.swap       (swap),
		.lb_wr      (lb_wr),
		.clear_busy (clear_busy),
		.hcnt       (hcnt),
		.pixel      (pixel)
	);

endmodule

`default_nettype wire

/* sprite_line_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sprite_consts.svh"

module sprite_line_buffer (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  swap,
	input  sprite_pkg::lb_write_t lb_wr,
	output logic                  clear_busy,
	input  logic [8:0]            hcnt,
	output sprite_pkg::rgb_t      pixel
);

	// Two slots of 512 entries, selected by the top address bit
	sprite_pkg::color_t mem [0:1023];

	logic read_slot;
	logic write_slot;
	sprite_pkg::line_x_t clear_x;

	sprite_pkg::lb_addr_t wr_addr;
	sprite_pkg::color_t wr_data;
	logic wr_en;

	sprite_pkg::lb_addr_t rd_addr;
	sprite_pkg::color_t rd_data;

	assign write_slot = ~read_slot;

	// Clearing owns the write port until the whole slot is zero
	assign wr_en = clear_busy | lb_wr.we;
	assign wr_addr = clear_busy ? {write_slot, clear_x} : {write_slot, lb_wr.x};
	assign wr_data = clear_busy ? '0 : lb_wr.color;

	assign rd_addr = {read_slot, hcnt + 9'(`READ_OFFSET)};

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			read_slot <= 1'b0;
			clear_busy <= 1'b0;
			clear_x <= '0;
		end
		else if (swap)
		begin
			read_slot <= ~read_slot;
			clear_busy <= 1'b1;
			clear_x <= '0;
		end
		else if (clear_busy)
		begin
			if (clear_x == sprite_pkg::line_x_t'(`LINE_LAST))
				clear_busy <= 1'b0;
			else
				clear_x <= clear_x + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];
	end

	// 5-bit channels widen by repeating their top bits
	assign pixel.r = {rd_data[4:0], rd_data[4:2]};
	assign pixel.g = {rd_data[9:5], rd_data[9:7]};
	assign pixel.b = {rd_data[14:10], rd_data[14:12]};
	assign pixel.a = rd_data[15];

endmodule

`default_nettype wire

/* sprite_pixel_drawer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sprite_consts.svh"

module sprite_pixel_drawer (
	input  logic                     clk,
	input  logic                     rst_n,
	input  sprite_pkg::sprite_desc_t desc,
	input  logic                     draw_start,
	output logic                     draw_done,
	output sprite_pkg::rom_addr_t    sprom_addr,
	input  logic [7:0]               sprom_data,
	output sprite_pkg::pal_addr_t    palrom_addr,
	input  sprite_pkg::color_t       palrom_data,
	output sprite_pkg::lb_write_t    lb_wr
);

	sprite_pkg::draw_state_t state;
	sprite_pkg::pix_t pix;
	logic last_pix;

	assign last_pix = (pix == sprite_pkg::pix_t'(`SPR_SIZE - 1));

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= sprite_pkg::DRW_IDLE;
			draw_done <= 1'b0;
			lb_wr.we <= 1'b0;
			pix <= '0;
			sprom_addr <= '0;
			palrom_addr <= '0;
		end
		else
		begin
			draw_done <= 1'b0;
			lb_wr.we <= 1'b0;

			case (state)
				sprite_pkg::DRW_IDLE:
				begin
					if (draw_start)
					begin
						// Row start: image*256 + row*16
						sprom_addr <= {desc.image, desc.row, 4'b0000};
						pix <= '0;
						state <= sprite_pkg::DRW_ROM_WAIT;
					end
				end

				sprite_pkg::DRW_ROM_WAIT:
				begin
					state <= sprite_pkg::DRW_ROM_DATA;
				end

				sprite_pkg::DRW_ROM_DATA:
				begin
					palrom_addr <= {desc.pal, sprom_data[4:0], 1'b0};
					state <= sprite_pkg::DRW_PAL_WAIT;
				end

				sprite_pkg::DRW_PAL_WAIT:
				begin
					state <= sprite_pkg::DRW_PAL_DATA;
				end

				// Alpha bit decides whether anything lands in the buffer
				sprite_pkg::DRW_PAL_DATA:
				begin
					lb_wr.we <= palrom_data[15];
					lb_wr.x <= desc.x[8:0] + sprite_pkg::line_x_t'(pix);
					lb_wr.color <= palrom_data;
					state <= sprite_pkg::DRW_NEXT;
				end

				sprite_pkg::DRW_NEXT:
				begin
					if (last_pix)
					begin
						draw_done <= 1'b1;
						state <= sprite_pkg::DRW_IDLE;
					end
					else
					begin
						pix <= pix + 1'b1;
						sprom_addr <= sprom_addr + 1'b1;
						state <= sprite_pkg::DRW_ROM_WAIT;
					end
				end

				default:
				begin
					state <= sprite_pkg::DRW_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* sprite_line_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sprite_consts.svh"

module sprite_line_sequencer (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    hsync,
	input  logic [8:0]              vcnt,
	input  logic                    clear_busy,
	input  logic                    draw_done,
	output logic                    swap,
	output sprite_pkg::sram_addr_t  spriteram_addr,
	input  logic [7:0]              spriteram_data,
	output sprite_pkg::sprite_desc_t desc,
	output logic                    draw_start
);

	sprite_pkg::seq_state_t state;

	logic hsync_last;
	logic hsync_rise;

	sprite_pkg::sprite_idx_t idx;
	sprite_pkg::coord_t active;

	// Attribute fields collected over the byte reads
	logic spr_en;
	sprite_pkg::pal_idx_t spr_pal;
	sprite_pkg::coord_t spr_y;
	sprite_pkg::image_idx_t spr_img;
	logic [1:0] spr_x_hi;

	sprite_pkg::coord_t row_diff;
	logic band_hit;
	logic last_sprite;

	// The row difference is only trusted when active is not below Y
	assign row_diff = active - spr_y;
	assign band_hit = spr_en && (active >= spr_y) &&
		(row_diff < sprite_pkg::coord_t'(`SPR_SIZE));
	assign last_sprite = (idx == sprite_pkg::sprite_idx_t'(`SPR_COUNT - 1));

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= sprite_pkg::SEQ_IDLE;
			hsync_last <= 1'b0;
			hsync_rise <= 1'b0;
			swap <= 1'b0;
			draw_start <= 1'b0;
			idx <= '0;
			spriteram_addr <= '0;
		end
		else
		begin
			hsync_last <= hsync;
			hsync_rise <= hsync & ~hsync_last;
			swap <= 1'b0;
			draw_start <= 1'b0;

			case (state)
				sprite_pkg::SEQ_IDLE:
				begin
					// Edges seen in any other state are dropped
					if (hsync_rise)
					begin
						swap <= 1'b1;
						active <= sprite_pkg::coord_t'(vcnt) +
							sprite_pkg::coord_t'(`SPR_SIZE);
						state <= sprite_pkg::SEQ_SWAP;
					end
				end

				// clear_busy only rises once the buffer has seen swap
				sprite_pkg::SEQ_SWAP:
				begin
					idx <= '0;
					state <= sprite_pkg::SEQ_CLEAR;
				end

				sprite_pkg::SEQ_CLEAR:
				begin
					if (!clear_busy)
						state <= sprite_pkg::SEQ_ADDR;
				end

				sprite_pkg::SEQ_ADDR:
				begin
					spriteram_addr <= sprite_pkg::sram_addr_t'(idx) *
						sprite_pkg::sram_addr_t'(`SPR_ATTR_STRIDE);
					state <= sprite_pkg::SEQ_RD_WAIT;
				end

				sprite_pkg::SEQ_RD_WAIT:
				begin
					spriteram_addr <= spriteram_addr + 1'b1;
					state <= sprite_pkg::SEQ_RD_CTRL;
				end

				// Byte 0 holds enable, palette and Y high bits
				sprite_pkg::SEQ_RD_CTRL:
				begin
					spr_en <= spriteram_data[7];
					spr_pal <= spriteram_data[5:4];
					spr_y[9:8] <= spriteram_data[1:0];
					spriteram_addr <= spriteram_addr + 1'b1;
					state <= sprite_pkg::SEQ_RD_YLO;
				end

				sprite_pkg::SEQ_RD_YLO:
				begin
					spr_y[7:0] <= spriteram_data;
					spriteram_addr <= spriteram_addr + 1'b1;
					state <= sprite_pkg::SEQ_RD_IMG;
				end

				// Byte 2 holds image index and X high bits
				sprite_pkg::SEQ_RD_IMG:
				begin
					spr_img <= spriteram_data[7:2];
					spr_x_hi <= spriteram_data[1:0];
					state <= sprite_pkg::SEQ_CHECK;
				end

				// Byte 3 (X low) is on the bus during the check
				sprite_pkg::SEQ_CHECK:
				begin
					if (band_hit)
					begin
						desc.image <= spr_img;
						desc.pal <= spr_pal;
						desc.x <= {spr_x_hi, spriteram_data};
						desc.row <= row_diff[3:0];
						draw_start <= 1'b1;
						state <= sprite_pkg::SEQ_DRAW;
					end
					else if (last_sprite)
						state <= sprite_pkg::SEQ_IDLE;
					else
					begin
						idx <= idx + 1'b1;
						state <= sprite_pkg::SEQ_ADDR;
					end
				end

				sprite_pkg::SEQ_DRAW:
				begin
					if (draw_done)
					begin
						if (last_sprite)
							state <= sprite_pkg::SEQ_IDLE;
						else
						begin
							idx <= idx + 1'b1;
							state <= sprite_pkg::SEQ_ADDR;
						end
					end
				end

				default:
				begin
					state <= sprite_pkg::SEQ_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* sprite_pkg.sv */
`default_nettype none

`include "sprite_consts.svh"

package sprite_pkg;

	// Widths with a meaning of their own
	typedef logic [$clog2(`SPR_COUNT)-1:0] sprite_idx_t;
	typedef logic [9:0] coord_t;
	typedef logic [8:0] line_x_t;
	typedef logic [9:0] lb_addr_t;
	typedef logic [15:0] color_t;
	typedef logic [$clog2(`SPR_SIZE)-1:0] row_t;
	typedef logic [$clog2(`SPR_SIZE)-1:0] pix_t;

	// Attribute fields and external address widths
	typedef logic [5:0] image_idx_t;
	typedef logic [1:0] pal_idx_t;
	typedef logic [6:0] sram_addr_t;
	typedef logic [13:0] rom_addr_t;
	typedef logic [7:0] pal_addr_t;

	// One sprite row to draw, handed from sequencer to drawer
	typedef struct packed {
		image_idx_t image;
		pal_idx_t pal;
		coord_t x;
		row_t row;
	} sprite_desc_t;

	// Pixel write into the current write slot
	typedef struct packed {
		logic we;
		line_x_t x;
		color_t color;
	} lb_write_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		logic a;
	} rgb_t;

	typedef enum logic [3:0] {
		SEQ_IDLE,
		SEQ_SWAP,
		SEQ_CLEAR,
		SEQ_ADDR,
		SEQ_RD_WAIT,
		SEQ_RD_CTRL,
		SEQ_RD_YLO,
		SEQ_RD_IMG,
		SEQ_CHECK,
		SEQ_DRAW
	} seq_state_t;

	typedef enum logic [2:0] {
		DRW_IDLE,
		DRW_ROM_WAIT,
		DRW_ROM_DATA,
		DRW_PAL_WAIT,
		DRW_PAL_DATA,
		DRW_NEXT
	} draw_state_t;

endpackage

`default_nettype wire

/* sprite_consts.svh */
`ifndef SPRITE_CONSTS_SVH
`define SPRITE_CONSTS_SVH

// Number of entries in sprite attribute RAM
`define SPR_COUNT 32

// Width and height of one sprite in pixels
`define SPR_SIZE 16

// Bytes per attribute entry in sprite RAM
`define SPR_ATTR_STRIDE 4

// Last line-buffer x cleared after each swap
`define LINE_LAST 352

// Added to hcnt to form the readout x
`define READ_OFFSET 18

`endif
